// ==== logic/lrelu_geom_pkg.sv ====
package lrelu_geom_pkg;

  // channel groups, each with its own constant set
  localparam int GROUPS = 2;

  // words per group in one data beat
  localparam int UNITS = 4;

  // config set is scale, then bias, then offset
  localparam int CONFIG_BEATS = 3;
  localparam int BEAT_SCALE   = 0;
  localparam int BEAT_BIAS    = 1;
  localparam int BEAT_OFFSET  = 2;

  // enabled cycles through each half of the datapath
  localparam int AFFINE_LATENCY = 2;
  localparam int ACT_LATENCY    = 2;
  localparam int PIPE_LATENCY   = AFFINE_LATENCY + ACT_LATENCY;

  // holds 0 up to CONFIG_BEATS inclusive
  localparam int CONFIG_COUNT_WIDTH = $clog2(CONFIG_BEATS + 1);

  typedef logic [CONFIG_COUNT_WIDTH-1:0] config_count_t;

endpackage

// ==== logic/lrelu_num_pkg.sv ====
package lrelu_num_pkg;

  // accumulator input and saturated output
  localparam int IN_WIDTH  = 20;
  localparam int OUT_WIDTH = 8;

  // constants are signed, 8 fractional bits
  localparam int CFG_WIDTH = 16;
  localparam int FRAC_BITS = 8;

  // (IN_WIDTH + CFG_WIDTH - FRAC_BITS) holds x*A>>FRAC plus bias
  localparam int AFFINE_WIDTH = 28;

  // alpha = 13/128, close to 0.1
  localparam int LRELU_ALPHA_NUM   = 13;
  localparam int LRELU_ALPHA_SHIFT = 7;

  // user sideband
  localparam int USER_WIDTH = 4;
  localparam int I_IS_LRELU = 0;

  typedef logic signed [IN_WIDTH-1:0]     acc_t;
  typedef logic signed [CFG_WIDTH-1:0]    cfg_t;
  typedef logic signed [AFFINE_WIDTH-1:0] affine_t;
  typedef logic signed [OUT_WIDTH-1:0]    out_t;
  typedef logic        [USER_WIDTH-1:0]   user_t;

  // sideband that rides alongside the data pipeline
  typedef struct packed {
    logic  valid;
    logic  last;
    user_t user;
  } side_t;

endpackage

// ==== logic/lrelu_delay_line.sv ====
`timescale 1ns/1ps

module lrelu_delay_line #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     clken,
  input  payload_t data_in,
  output payload_t mid_out,
  output payload_t data_out
);

  localparam int DEPTH = lrelu_geom_pkg::PIPE_LATENCY;
  localparam int TAP   = lrelu_geom_pkg::AFFINE_LATENCY;

  payload_t stage_q [DEPTH];

  // zero reset keeps valid and last low until real beats arrive
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else if (clken) begin
      stage_q[0] <= data_in;
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // tap lines up with the affine result
  assign mid_out  = stage_q[TAP-1];
  assign data_out = stage_q[DEPTH-1];

endmodule

// ==== logic/lrelu_config_loader.sv ====
`timescale 1ns/1ps

module lrelu_config_loader (
  input  logic                                                 clk,
  input  logic                                                 arst_n,
  input  logic                                                 clken,
  input  logic                                                 s_valid_config,
  input  logic                                                 config_restart,
  input  logic [lrelu_geom_pkg::GROUPS*lrelu_num_pkg::CFG_WIDTH-1:0] config_data,
  output lrelu_num_pkg::cfg_t                                  scale  [lrelu_geom_pkg::GROUPS],
  output lrelu_num_pkg::cfg_t                                  bias   [lrelu_geom_pkg::GROUPS],
  output lrelu_num_pkg::cfg_t                                  offset [lrelu_geom_pkg::GROUPS],
  output logic                                                 count_config_full
);

  localparam int GROUPS = lrelu_geom_pkg::GROUPS;
  localparam int W      = lrelu_num_pkg::CFG_WIDTH;

  lrelu_geom_pkg::config_count_t count_q;
  logic                          full_q;
  logic                          restart;
  logic                          write_en;
  lrelu_num_pkg::cfg_t           config_word [GROUPS];

  // group g sits at bits [g*W +: W]
  for (genvar g = 0; g < GROUPS; g++) begin : g_split
    assign config_word[g] = config_data[g*W +: W];
  end

  assign restart  = clken && config_restart;
  // restart wins over a beat on the same edge
  assign write_en = clken && s_valid_config && !full_q && !config_restart;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count_q <= '0;
      full_q  <= 1'b0;
    end else if (restart) begin
      count_q <= '0;
      full_q  <= 1'b0;
    end else if (write_en) begin
      count_q <= count_q + 1'b1;
      if (count_q == lrelu_geom_pkg::config_count_t'(lrelu_geom_pkg::CONFIG_BEATS - 1)) begin
        full_q <= 1'b1;
      end
    end
  end

  // beat number picks the bank for all groups at once
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int g = 0; g < GROUPS; g++) begin
        scale[g]  <= '0;
        bias[g]   <= '0;
        offset[g] <= '0;
      end
    end else if (write_en) begin
      for (int g = 0; g < GROUPS; g++) begin
        case (count_q)
          lrelu_geom_pkg::config_count_t'(lrelu_geom_pkg::BEAT_SCALE):  scale[g]  <= config_word[g];
          lrelu_geom_pkg::config_count_t'(lrelu_geom_pkg::BEAT_BIAS):   bias[g]   <= config_word[g];
          lrelu_geom_pkg::config_count_t'(lrelu_geom_pkg::BEAT_OFFSET): offset[g] <= config_word[g];
          default: ;
        endcase
      end
    end
  end

  assign count_config_full = full_q;

  // counter rests at the set size exactly while the flag is up
  a_count_bound: assert property (
    @(posedge clk) disable iff (!arst_n)
    full_q == (count_q == lrelu_geom_pkg::config_count_t'(lrelu_geom_pkg::CONFIG_BEATS))
  );

endmodule

// ==== logic/lrelu_affine_unit.sv ====
`timescale 1ns/1ps

module lrelu_affine_unit (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   clken,
  input  lrelu_num_pkg::acc_t    x,
  input  lrelu_num_pkg::cfg_t    scale,
  input  lrelu_num_pkg::cfg_t    bias,
  output lrelu_num_pkg::affine_t y
);

  localparam int PROD_WIDTH = lrelu_num_pkg::IN_WIDTH + lrelu_num_pkg::CFG_WIDTH;
  localparam int AW         = lrelu_num_pkg::AFFINE_WIDTH;

  logic signed [PROD_WIDTH-1:0] prod_q;
  logic signed [PROD_WIDTH-1:0] prod_shift;
  lrelu_num_pkg::cfg_t          bias_q;

  // stage one, full product, bias captured with the same beat
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prod_q <= '0;
      bias_q <= '0;
    end else if (clken) begin
      prod_q <= x * scale;
      bias_q <= bias;
    end
  end

  // floor division by 2^FRAC_BITS
  assign prod_shift = prod_q >>> lrelu_num_pkg::FRAC_BITS;

  // stage two, drop fraction and add bias
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      y <= '0;
    end else if (clken) begin
      y <= $signed(prod_shift[AW-1:0]) + lrelu_num_pkg::affine_t'(bias_q);
    end
  end

endmodule

// ==== logic/lrelu_activation_unit.sv ====
`timescale 1ns/1ps

module lrelu_activation_unit (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   clken,
  input  lrelu_num_pkg::affine_t y,
  input  logic                   is_lrelu,
  input  lrelu_num_pkg::cfg_t    offset,
  output lrelu_num_pkg::out_t    z
);

  localparam int AW        = lrelu_num_pkg::AFFINE_WIDTH;
  localparam int MUL_WIDTH = AW + 4;
  localparam int SUM_WIDTH = AW + 1;
  localparam int OUT_MAX   = 2 ** (lrelu_num_pkg::OUT_WIDTH - 1) - 1;
  localparam int OUT_MIN   = -(2 ** (lrelu_num_pkg::OUT_WIDTH - 1));

  logic signed [MUL_WIDTH-1:0] scaled;
  logic signed [MUL_WIDTH-1:0] scaled_shift;
  lrelu_num_pkg::affine_t      y2_next;
  lrelu_num_pkg::affine_t      y2_q;
  lrelu_num_pkg::cfg_t         offset_q;
  logic signed [SUM_WIDTH-1:0] sum;
  lrelu_num_pkg::out_t         z_next;

  // negative words scaled by alpha with floor rounding
  assign scaled       = y * lrelu_num_pkg::LRELU_ALPHA_NUM;
  assign scaled_shift = scaled >>> lrelu_num_pkg::LRELU_ALPHA_SHIFT;
  assign y2_next      = (is_lrelu && y[AW-1]) ? $signed(scaled_shift[AW-1:0]) : y;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      y2_q     <= '0;
      offset_q <= '0;
    end else if (clken) begin
      y2_q     <= y2_next;
      offset_q <= offset;
    end
  end

  // one extra bit so the offset add cannot wrap
  assign sum = SUM_WIDTH'(y2_q) + SUM_WIDTH'(offset_q);

  always_comb begin
    if (sum > OUT_MAX) begin
      z_next = lrelu_num_pkg::out_t'(OUT_MAX);
    end else if (sum < OUT_MIN) begin
      z_next = lrelu_num_pkg::out_t'(OUT_MIN);
    end else begin
      z_next = sum[lrelu_num_pkg::OUT_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      z <= '0;
    end else if (clken) begin
      z <= z_next;
    end
  end

  // leaky slope keeps a negative word negative and no larger in magnitude
  a_leak_bounded: assert property (
    @(posedge clk) disable iff (!arst_n)
    is_lrelu && y[AW-1] |-> (y2_next < 0) && (y2_next >= y)
  );

  // clamped output keeps the sign of the sum
  a_no_wrap: assert property (
    @(posedge clk) disable iff (!arst_n)
    clken |=> z[lrelu_num_pkg::OUT_WIDTH-1] == $past(sum[SUM_WIDTH-1])
  );

endmodule

// ==== logic/lrelu_engine.sv ====
`timescale 1ns/1ps

module lrelu_engine (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 clken,
  input  logic                 s_valid,
  input  logic                 s_last,
  input  lrelu_num_pkg::user_t s_user,
  input  logic [lrelu_geom_pkg::GROUPS*lrelu_geom_pkg::UNITS*lrelu_num_pkg::IN_WIDTH-1:0]
                               s_data_flat,
  output logic                 m_valid,
  output logic                 m_last,
  output lrelu_num_pkg::user_t m_user,
  output logic [lrelu_geom_pkg::GROUPS*lrelu_geom_pkg::UNITS*lrelu_num_pkg::OUT_WIDTH-1:0]
                               m_data_flat,
  input  logic                 s_valid_config,
  input  logic                 config_restart,
  input  logic [lrelu_geom_pkg::GROUPS*lrelu_num_pkg::CFG_WIDTH-1:0] config_data,
  output logic                 count_config_full
);

  localparam int GROUPS = lrelu_geom_pkg::GROUPS;
  localparam int UNITS  = lrelu_geom_pkg::UNITS;
  localparam int IW     = lrelu_num_pkg::IN_WIDTH;
  localparam int OW     = lrelu_num_pkg::OUT_WIDTH;

  lrelu_num_pkg::cfg_t  scale  [GROUPS];
  lrelu_num_pkg::cfg_t  bias   [GROUPS];
  lrelu_num_pkg::cfg_t  offset [GROUPS];
  lrelu_num_pkg::side_t side_in;
  lrelu_num_pkg::side_t side_mid;
  lrelu_num_pkg::side_t side_out;
  logic                 is_lrelu;

  lrelu_config_loader u_config (
    .clk               (clk),
    .arst_n            (arst_n),
    .clken             (clken),
    .s_valid_config    (s_valid_config),
    .config_restart    (config_restart),
    .config_data       (config_data),
    .scale             (scale),
    .bias              (bias),
    .offset            (offset),
    .count_config_full (count_config_full)
  );

  // valid, last and user ride a delay line matched to the datapath
  assign side_in.valid = s_valid;
  assign side_in.last  = s_last;
  assign side_in.user  = s_user;

  lrelu_delay_line #(
    .payload_t (lrelu_num_pkg::side_t)
  ) u_side_delay (
    .clk      (clk),
    .arst_n   (arst_n),
    .clken    (clken),
    .data_in  (side_in),
    .mid_out  (side_mid),
    .data_out (side_out)
  );

  // mid tap reaches the activation stage with its own beat
  assign is_lrelu = side_mid.user[lrelu_num_pkg::I_IS_LRELU];

  assign m_valid = side_out.valid;
  assign m_last  = side_out.last;
  assign m_user  = side_out.user;

  // word (g,u) sits at flat index g*UNITS+u, lowest bits first
  for (genvar g = 0; g < GROUPS; g++) begin : g_group
    for (genvar u = 0; u < UNITS; u++) begin : g_unit
      localparam int IDX = g * UNITS + u;

      lrelu_num_pkg::acc_t    x_word;
      lrelu_num_pkg::affine_t y_word;
      lrelu_num_pkg::out_t    z_word;

      assign x_word = s_data_flat[IDX*IW +: IW];

      lrelu_affine_unit u_affine (
        .clk    (clk),
        .arst_n (arst_n),
        .clken  (clken),
        .x      (x_word),
        .scale  (scale[g]),
        .bias   (bias[g]),
        .y      (y_word)
      );

      lrelu_activation_unit u_act (
        .clk      (clk),
        .arst_n   (arst_n),
        .clken    (clken),
        .y        (y_word),
        .is_lrelu (is_lrelu),
        .offset   (offset[g]),
        .z        (z_word)
      );

      assign m_data_flat[IDX*OW +: OW] = z_word;
    end
  end

  // data must wait for a complete constant set
  a_data_after_config: assert property (
    @(posedge clk) disable iff (!arst_n)
    clken && s_valid |-> count_config_full
  );

  // stream control known once out of reset
  a_known_ctrl: assert property (
    @(posedge clk) disable iff (!arst_n)
    !$isunknown({m_valid, m_last, count_config_full})
  );

endmodule

// ==== bench/lrelu_model.svh ====
// expected output beat and the enabled edge that took its input
typedef struct packed {
  logic [OUT_BITS-1:0]  data;
  logic                 last;
  lrelu_num_pkg::user_t user;
  int                   edge_idx;
} expect_t;

expect_t exp_q [$];

// constant banks and beat counter as the bench expects them
lrelu_num_pkg::cfg_t model_a [GROUPS];
lrelu_num_pkg::cfg_t model_b [GROUPS];
lrelu_num_pkg::cfg_t model_d [GROUPS];
int                  model_count;
logic                model_full;

function automatic void model_reset();
  for (int g = 0; g < GROUPS; g++) begin
    model_a[g] = '0;
    model_b[g] = '0;
    model_d[g] = '0;
  end
  model_count = 0;
  model_full  = 1'b0;
endfunction

// one config edge: restart first, otherwise fill the next bank
function automatic void model_config_step(input logic restart, input logic valid,
                                          input logic [CFG_BITS-1:0] cd);
  lrelu_num_pkg::cfg_t w;
  if (restart) begin
    model_count = 0;
    model_full  = 1'b0;
  end else if (valid && !model_full) begin
    for (int g = 0; g < GROUPS; g++) begin
      w = cd[g*CW +: CW];
      if (model_count == lrelu_geom_pkg::BEAT_SCALE) begin
        model_a[g] = w;
      end else if (model_count == lrelu_geom_pkg::BEAT_BIAS) begin
        model_b[g] = w;
      end else if (model_count == lrelu_geom_pkg::BEAT_OFFSET) begin
        model_d[g] = w;
      end
    end
    model_count++;
    if (model_count == lrelu_geom_pkg::CONFIG_BEATS) begin
      model_full = 1'b1;
    end
  end
endfunction

// scale and bias, leaky slope on negatives, offset, clamp
function automatic logic [OUT_W-1:0] model_word(input longint x, input longint a,
                                                input longint b, input longint d,
                                                input logic lrelu);
  longint y;
  longint hi;
  longint lo;
  hi = (longint'(1) << (OUT_W - 1)) - 1;
  lo = -(longint'(1) << (OUT_W - 1));
  y  = ((x * a) >>> lrelu_num_pkg::FRAC_BITS) + b;
  if (lrelu && y < 0) begin
    y = (y * lrelu_num_pkg::LRELU_ALPHA_NUM) >>> lrelu_num_pkg::LRELU_ALPHA_SHIFT;
  end
  y = y + d;
  if (y > hi) begin
    y = hi;
  end else if (y < lo) begin
    y = lo;
  end
  return y[OUT_W-1:0];
endfunction

function automatic void push_expected(input logic [IN_BITS-1:0] d, input logic l,
                                      input lrelu_num_pkg::user_t u, input int idx);
  expect_t             e;
  lrelu_num_pkg::acc_t xw;
  int                  g;
  for (int i = 0; i < GROUPS * UNITS; i++) begin
    g  = i / UNITS;
    xw = d[i*IW +: IW];
    e.data[i*OUT_W +: OUT_W] = model_word(xw, model_a[g], model_b[g], model_d[g],
                                          u[lrelu_num_pkg::I_IS_LRELU]);
  end
  e.last     = l;
  e.user     = u;
  e.edge_idx = idx;
  exp_q.push_back(e);
endfunction

// ==== bench/tb_lrelu_engine.sv ====
`timescale 1ns/1ps

module tb_lrelu_engine;

  localparam int GROUPS   = lrelu_geom_pkg::GROUPS;
  localparam int UNITS    = lrelu_geom_pkg::UNITS;
  localparam int PIPE     = lrelu_geom_pkg::PIPE_LATENCY;
  localparam int IW       = lrelu_num_pkg::IN_WIDTH;
  localparam int OUT_W    = lrelu_num_pkg::OUT_WIDTH;
  localparam int CW       = lrelu_num_pkg::CFG_WIDTH;
  localparam int IN_BITS  = GROUPS * UNITS * IW;
  localparam int OUT_BITS = GROUPS * UNITS * OUT_W;
  localparam int CFG_BITS = GROUPS * CW;
  localparam lrelu_num_pkg::user_t LRELU_BIT = 1 << lrelu_num_pkg::I_IS_LRELU;

  localparam int RESET_CYCLES = 10;
  localparam int N_AFFINE     = 48;
  localparam int N_LRELU      = 48;
  localparam int N_STALL      = 64;
  localparam int N_RELOAD     = 32;
  // taken cycles of all tests, counted twice for clken stalls
  localparam int TEST_CYCLES = RESET_CYCLES + 2 * (N_AFFINE + N_LRELU + N_STALL + N_RELOAD
                               + 3 * lrelu_geom_pkg::CONFIG_BEATS + 16 * PIPE);
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                 clk;
  logic                 arst_n;
  logic                 clken;
  logic                 s_valid;
  logic                 s_last;
  lrelu_num_pkg::user_t s_user;
  logic [IN_BITS-1:0]   s_data_flat;
  logic                 m_valid;
  logic                 m_last;
  lrelu_num_pkg::user_t m_user;
  logic [OUT_BITS-1:0]  m_data_flat;
  logic                 s_valid_config;
  logic                 config_restart;
  logic [CFG_BITS-1:0]  config_data;
  logic                 count_config_full;

  int   seed;
  logic stall_on;
  int   errors;
  int   errors_before;
  int   checks;
  int   tests_run;
  int   en_count;
  int   cycles;

  `include "lrelu_model.svh"

  lrelu_engine DUT (
    .clk               (clk),
    .arst_n            (arst_n),
    .clken             (clken),
    .s_valid           (s_valid),
    .s_last            (s_last),
    .s_user            (s_user),
    .s_data_flat       (s_data_flat),
    .m_valid           (m_valid),
    .m_last            (m_last),
    .m_user            (m_user),
    .m_data_flat       (m_data_flat),
    .s_valid_config    (s_valid_config),
    .config_restart    (config_restart),
    .config_data       (config_data),
    .count_config_full (count_config_full)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic compare_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  // holds the inputs until an enabled edge takes them
  task automatic drive_taken(input logic v, input logic l, input lrelu_num_pkg::user_t u,
                             input logic [IN_BITS-1:0] d, input logic cv, input logic cr,
                             input logic [CFG_BITS-1:0] cd);
    logic en;
    do begin
      @(posedge clk);
      en = stall_on ? (({$random(seed)} % 10) < 8) : 1'b1;
      clken          <= en;
      s_valid        <= v;
      s_last         <= l;
      s_user         <= u;
      s_data_flat    <= d;
      s_valid_config <= cv;
      config_restart <= cr;
      config_data    <= cd;
    end while (!en);
  endtask

  task automatic send_beat(input logic [IN_BITS-1:0] d, input logic l,
                           input lrelu_num_pkg::user_t u);
    drive_taken(1'b1, l, u, d, 1'b0, 1'b0, '0);
  endtask

  task automatic send_config(input logic [CFG_BITS-1:0] cd);
    drive_taken(1'b0, 1'b0, '0, '0, 1'b1, 1'b0, cd);
  endtask

  task automatic idle_cycle();
    drive_taken(1'b0, 1'b0, '0, '0, 1'b0, 1'b0, '0);
  endtask

  // wait out the pipeline, then a few more edges to catch strays
  task automatic drain();
    while (exp_q.size() != 0) begin
      idle_cycle();
    end
    for (int i = 0; i < PIPE + 2; i++) begin
      idle_cycle();
    end
  endtask

  // magnitude spread over 4 to 19 bits, so some words saturate
  function automatic lrelu_num_pkg::acc_t rand_acc(input int neg_pct);
    int bits;
    int v;
    bits = 4 + ({$random(seed)} % 16);
    v    = {$random(seed)} % (1 << bits);
    if (({$random(seed)} % 100) < neg_pct) begin
      v = -v;
    end
    return lrelu_num_pkg::acc_t'(v);
  endfunction

  function automatic logic [IN_BITS-1:0] rand_data(input int neg_pct);
    logic [IN_BITS-1:0] d;
    for (int i = 0; i < GROUPS * UNITS; i++) begin
      d[i*IW +: IW] = rand_acc(neg_pct);
    end
    return d;
  endfunction

  function automatic logic [CFG_BITS-1:0] rand_config(input int lo, input int span);
    logic [CFG_BITS-1:0] cd;
    for (int g = 0; g < GROUPS; g++) begin
      cd[g*CW +: CW] = CW'(lo + int'({$random(seed)} % span));
    end
    return cd;
  endfunction

  // scale, bias, offset in beat order
  task automatic load_constants(input int scale_lo, input int scale_span);
    send_config(rand_config(scale_lo, scale_span));
    send_config(rand_config(-2048, 4096));
    send_config(rand_config(-64, 128));
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
    errors_before = errors;
  endtask

  // inputs and outputs are steady at the falling edge
  always @(negedge clk) begin
    expect_t e;
    cycles++;
    if (arst_n) begin
      compare_value("count_config_full", count_config_full, model_full);
      if (clken) begin
        if (m_valid) begin
          if (exp_q.size() == 0) begin
            errors++;
            $display("error at %0t ns: output beat with no input beat pending", $time);
          end else begin
            e = exp_q.pop_front();
            compare_value("m_data_flat", m_data_flat, e.data);
            compare_value("m_last", m_last, e.last);
            compare_value("m_user", m_user, e.user);
            compare_value("latency in enabled edges", en_count - e.edge_idx, PIPE);
          end
        end
        if (s_valid) begin
          push_expected(s_data_flat, s_last, s_user, en_count);
        end
        model_config_step(config_restart, s_valid_config, config_data);
        en_count++;
      end
    end
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, %0d beats never came out", cycles, exp_q.size());
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    lrelu_num_pkg::user_t user;
    seed           = 32'h7e8c6500;
    stall_on       = 1'b0;
    errors         = 0;
    errors_before  = 0;
    checks         = 0;
    tests_run      = 0;
    en_count       = 0;
    cycles         = 0;
    arst_n         = 1'b0;
    clken          = 1'b0;
    s_valid        = 1'b0;
    s_last         = 1'b0;
    s_user         = '0;
    s_data_flat    = '0;
    s_valid_config = 1'b0;
    config_restart = 1'b0;
    config_data    = '0;
    model_reset();
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;

    @(negedge clk);
    compare_value("m_valid after reset", m_valid, 0);
    compare_value("m_last after reset", m_last, 0);
    compare_value("count_config_full after reset", count_config_full, 0);
    end_test("reset_state");

    // extra beats after the set is full must be ignored
    load_constants(-512, 1024);
    idle_cycle();
    @(negedge clk);
    compare_value("count_config_full after set", count_config_full, 1);
    send_config(rand_config(-32768, 65536));
    send_config(rand_config(-32768, 65536));
    idle_cycle();
    end_test("config_load");

    for (int i = 0; i < N_AFFINE; i++) begin
      user = lrelu_num_pkg::user_t'($random(seed)) & ~LRELU_BIT;
      send_beat(rand_data(50), i == N_AFFINE - 1, user);
    end
    drain();
    end_test("affine_path");

    for (int i = 0; i < N_LRELU; i++) begin
      user = lrelu_num_pkg::user_t'($random(seed)) | LRELU_BIT;
      send_beat(rand_data(80), i == N_LRELU - 1, user);
    end
    drain();
    end_test("leaky_relu");

    stall_on = 1'b1;
    for (int i = 0; i < N_STALL; i++) begin
      user = lrelu_num_pkg::user_t'($random(seed));
      send_beat(rand_data(50), ({$random(seed)} % 8) == 0, user);
    end
    drain();
    end_test("clken_stalls");

    // new constants only once the pipeline is empty
    drive_taken(1'b0, 1'b0, '0, '0, 1'b0, 1'b1, '0);
    load_constants(64, 512);
    idle_cycle();
    for (int i = 0; i < N_RELOAD; i++) begin
      user = lrelu_num_pkg::user_t'($random(seed));
      send_beat(rand_data(60), i == N_RELOAD - 1, user);
    end
    drain();
    end_test("config_reload");

    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+bench
logic/lrelu_geom_pkg.sv
logic/lrelu_num_pkg.sv
logic/lrelu_delay_line.sv
logic/lrelu_config_loader.sv
logic/lrelu_affine_unit.sv
logic/lrelu_activation_unit.sv
logic/lrelu_engine.sv
bench/tb_lrelu_engine.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, decide from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_lrelu_engine -o tb_lrelu_engine -f sim.f > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_lrelu_engine > sim.log 2>&1
cat sim.log

grep -Fqx "*** TEST PASSED ***" sim.log && exit 0 \
  || { echo "simulation failed, see sim.log"; exit 1; }
